// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       ?= tb_tinker_core
FILELIST  ?= tinker_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tinker_programs.svh ====
// Test programs and their expected stores, included into the testbench top
task automatic build_programs();
    tinker_isa_pkg::word_t a;
    tinker_isa_pkg::word_t b;
    tinker_isa_pkg::word_t v;
    logic [31:0]           rnd;
    // Test 0 and 1: logic and arithmetic on LCG literals
    for (int t = 0; t < 2; t++) begin
        rnd = lcg_next();
        a = {52'd0, rnd[11:0]};
        rnd = lcg_next();
        b = {52'd0, rnd[11:0]};
        names[t] = (t == 0) ? "add/sub/and" : "or/xor/not";
        add_instr(t, encode(tinker_isa_pkg::OP_MOV_RL, 1, 0, 0, a[11:0]));
        add_instr(t, encode(tinker_isa_pkg::OP_MOV_RL, 2, 0, 0, b[11:0]));
        add_instr(t, encode((t == 0) ? tinker_isa_pkg::OP_ADD : tinker_isa_pkg::OP_OR, 3, 1, 2, 0));
        add_instr(t, encode((t == 0) ? tinker_isa_pkg::OP_SUB : tinker_isa_pkg::OP_XOR, 4, 1, 2, 0));
        add_instr(t, encode((t == 0) ? tinker_isa_pkg::OP_AND : tinker_isa_pkg::OP_NOT, 5, 1, 2, 0));
        for (int k = 0; k < 3; k++) begin
            add_instr(t, encode(tinker_isa_pkg::OP_STORE, 0, 3 + k, 0, 12'h100 + 12'(8 * k)));
        end
        add_instr(t, encode(tinker_isa_pkg::OP_HALT, 0, 0, 0, 0));
        add_store(t, 32'h100, (t == 0) ? a + b : a | b);
        add_store(t, 32'h108, (t == 0) ? a - b : a ^ b);
        add_store(t, 32'h110, (t == 0) ? a & b : ~a);
    end
    // Test 2: immediates, both shift forms, mov keeping the upper bits
    names[2] = "immediates/shifts";
    add_instr(2, encode(tinker_isa_pkg::OP_MOV_RL, 1, 0, 0, 12'h123));
    add_instr(2, encode(tinker_isa_pkg::OP_SHFTLI, 1, 0, 0, 12'd12));
    add_instr(2, encode(tinker_isa_pkg::OP_MOV_RL, 1, 0, 0, 12'h456));
    add_instr(2, encode(tinker_isa_pkg::OP_STORE, 0, 1, 0, 12'h200));
    add_instr(2, encode(tinker_isa_pkg::OP_ADDI, 1, 0, 0, 12'hff0));   // -16
    add_instr(2, encode(tinker_isa_pkg::OP_STORE, 0, 1, 0, 12'h208));
    add_instr(2, encode(tinker_isa_pkg::OP_SUBI, 1, 0, 0, 12'h800));
    add_instr(2, encode(tinker_isa_pkg::OP_STORE, 0, 1, 0, 12'h210));
    add_instr(2, encode(tinker_isa_pkg::OP_MOV_RL, 3, 0, 0, 12'd4));
    add_instr(2, encode(tinker_isa_pkg::OP_SHFTR, 4, 1, 3, 0));
    add_instr(2, encode(tinker_isa_pkg::OP_STORE, 0, 4, 0, 12'h218));
    add_instr(2, encode(tinker_isa_pkg::OP_HALT, 0, 0, 0, 0));
    v = 64'h123 << 12;
    v = {v[63:12], 12'h456};
    add_store(2, 32'h200, v);
    v = v - 64'd16;
    add_store(2, 32'h208, v);
    v = v - 64'h800;
    add_store(2, 32'h210, v);
    add_store(2, 32'h218, v >> 4);
    // Test 3: store, load back, store again
    names[3] = "load/store";
    add_instr(3, encode(tinker_isa_pkg::OP_MOV_RL, 1, 0, 0, 12'habc));
    add_instr(3, encode(tinker_isa_pkg::OP_SHFTLI, 1, 0, 0, 12'd12));
    add_instr(3, encode(tinker_isa_pkg::OP_MOV_RL, 1, 0, 0, 12'h5a5));
    add_instr(3, encode(tinker_isa_pkg::OP_MOV_RL, 2, 0, 0, 12'h300));
    add_instr(3, encode(tinker_isa_pkg::OP_STORE, 2, 1, 0, 12'h010));
    add_instr(3, encode(tinker_isa_pkg::OP_LOAD, 3, 2, 0, 12'h010));
    add_instr(3, encode(tinker_isa_pkg::OP_STORE, 2, 3, 0, 12'h020));
    add_instr(3, encode(tinker_isa_pkg::OP_HALT, 0, 0, 0, 0));
    add_store(3, 32'h310, 64'habc5a5);
    add_store(3, 32'h320, 64'habc5a5);
    // Test 4: brr L, brnz not taken then taken; r5 holds the target 0x2024
    names[4] = "brr/brnz";
    add_instr(4, encode(tinker_isa_pkg::OP_MOV_RL, 5, 0, 0, 12'h2));
    add_instr(4, encode(tinker_isa_pkg::OP_SHFTLI, 5, 0, 0, 12'd12));
    add_instr(4, encode(tinker_isa_pkg::OP_ADDI, 5, 0, 0, 12'h024));
    add_instr(4, encode(tinker_isa_pkg::OP_BRR_L, 0, 0, 0, 12'd8));
    add_instr(4, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h400));   // Skipped
    add_instr(4, encode(tinker_isa_pkg::OP_BRNZ, 5, 0, 0, 0));
    add_instr(4, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h408));
    add_instr(4, encode(tinker_isa_pkg::OP_BRNZ, 5, 31, 0, 0));   // r31 is nonzero after reset
    add_instr(4, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h410));   // Skipped
    add_instr(4, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h418));
    add_instr(4, encode(tinker_isa_pkg::OP_HALT, 0, 0, 0, 0));
    add_store(4, 32'h408, 64'h2024);
    add_store(4, 32'h418, 64'h2024);
    // Test 5: brgt not taken then taken to r5 = 0x201c, r31 as the larger operand
    names[5] = "brgt";
    add_instr(5, encode(tinker_isa_pkg::OP_MOV_RL, 5, 0, 0, 12'h2));
    add_instr(5, encode(tinker_isa_pkg::OP_SHFTLI, 5, 0, 0, 12'd12));
    add_instr(5, encode(tinker_isa_pkg::OP_ADDI, 5, 0, 0, 12'h01c));
    add_instr(5, encode(tinker_isa_pkg::OP_BRGT, 5, 0, 5, 0));
    add_instr(5, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h500));
    add_instr(5, encode(tinker_isa_pkg::OP_BRGT, 5, 31, 0, 0));
    add_instr(5, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h508));   // Skipped
    add_instr(5, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h510));
    add_instr(5, encode(tinker_isa_pkg::OP_HALT, 0, 0, 0, 0));
    add_store(5, 32'h500, 64'h201c);
    add_store(5, 32'h510, 64'h201c);
    // Test 6: call at 0x200c into 0x2018, return to 0x2010
    names[6] = "call/return";
    add_instr(6, encode(tinker_isa_pkg::OP_MOV_RL, 5, 0, 0, 12'h2));
    add_instr(6, encode(tinker_isa_pkg::OP_SHFTLI, 5, 0, 0, 12'd12));
    add_instr(6, encode(tinker_isa_pkg::OP_ADDI, 5, 0, 0, 12'h018));
    add_instr(6, encode(tinker_isa_pkg::OP_CALL, 5, 0, 0, 0));
    add_instr(6, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h600));
    add_instr(6, encode(tinker_isa_pkg::OP_HALT, 0, 0, 0, 0));
    add_instr(6, encode(tinker_isa_pkg::OP_STORE, 0, 5, 0, 12'h608));
    add_instr(6, encode(tinker_isa_pkg::OP_RETURN, 0, 0, 0, 0));
    add_store(6, 32'(STACK_TOP) - 32'd8, 64'h2010);
    add_store(6, 32'h608, 64'h2018);
    add_store(6, 32'h600, 64'h2018);
    // Test 7: halt alone, no store may follow
    names[7] = "reset/halt";
    add_instr(7, encode(tinker_isa_pkg::OP_HALT, 0, 0, 0, 0));
endtask

// ==== bench/tb_tinker_core.sv ====
// Testbench for the Tinker core: models memory, runs each program to halt, checks stores
`default_nettype none

module tb_tinker_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int                    NT        = 8;
    localparam int                    MAX_INSTR = 12;
    localparam int                    MAX_ST    = 4;
    localparam int                    MEM_BYTES = 1 << 20;
    localparam tinker_isa_pkg::addr_t PROG_BASE = 32'h2000;
    localparam tinker_isa_pkg::word_t STACK_TOP = 64'h80000;

    logic                      clk;
    logic                      reset;
    tinker_core_pkg::mem_req_t mem_req;
    tinker_core_pkg::mem_rsp_t mem_rsp;
    logic                      hlt;

    logic [7:0]                mem [MEM_BYTES];
    tinker_isa_pkg::instr_t    prog [NT][MAX_INSTR];
    int                        prog_len [NT];
    tinker_isa_pkg::addr_t     exp_addr [NT][MAX_ST];
    tinker_isa_pkg::word_t     exp_data [NT][MAX_ST];
    int                        exp_cnt [NT];
    string                     names [NT];
    tinker_isa_pkg::addr_t     seen_addr [$];
    tinker_isa_pkg::word_t     seen_data [$];
    logic                      pend_we;
    tinker_isa_pkg::addr_t     pend_addr;
    tinker_isa_pkg::word_t     pend_data;
    logic [31:0]               lcg_state = 32'h93b97a1a;
    int                        errors = 0;
    int                        checks = 0;
    int                        cur_test = 0;
    bit                        tables_ready = 0;

    tinker_core #(.RESET_PC(PROG_BASE), .STACK_TOP(STACK_TOP)) dut (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .hlt     (hlt)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic tinker_isa_pkg::instr_t encode(tinker_isa_pkg::opcode_e op,
            int rd, int rs, int rt, logic [11:0] lit);
        return {5'(op), 5'(rd), 5'(rs), 5'(rt), lit};
    endfunction

    task automatic add_instr(int t, tinker_isa_pkg::instr_t ins);
        prog[t][prog_len[t]] = ins;
        prog_len[t]++;
    endtask

    task automatic add_store(int t, tinker_isa_pkg::addr_t addr, tinker_isa_pkg::word_t data);
        exp_addr[t][exp_cnt[t]] = addr;
        exp_data[t][exp_cnt[t]] = data;
        exp_cnt[t]++;
    endtask

    `include "tinker_programs.svh"

    task automatic check_word(string name, tinker_isa_pkg::word_t exp, tinker_isa_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(string name, tinker_isa_pkg::addr_t exp, tinker_isa_pkg::addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Big-endian reads, answered in the same cycle
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mem_rsp.instruction[31 - 8*i -: 8] = mem[20'(mem_req.fetch_addr + 32'(i))];
        end
        for (int i = 0; i < 8; i++) begin
            mem_rsp.load_data[63 - 8*i -: 8] = mem[20'(mem_req.load_addr + 32'(i))];
        end
    end

    always @(negedge clk) begin
        pend_we = !reset && mem_req.store_we;   // Sampled mid-cycle
        pend_addr = mem_req.store_addr;
        pend_data = mem_req.store_data;
        if (pend_we) begin
            seen_addr.push_back(pend_addr);
            seen_data.push_back(pend_data);
        end
    end

    always @(posedge clk) begin
        if (pend_we) begin
            for (int i = 0; i < 8; i++) begin
                mem[20'(pend_addr + 32'(i))] <= pend_data[63 - 8*i -: 8];
            end
        end
    end

    initial begin
        longint limit;
        wait (tables_ready);
        limit = 0;
        for (int t = 0; t < NT; t++) begin
            limit += 10 + 10 + 5 * prog_len[t] + 30;   // Reset, spacing, 5 per instruction
        end
        #(limit * 20);
        $display("Watchdog expired: test %0d (%s) never reached halt", cur_test, names[cur_test]);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int n;
        int t_err;
        reset = 1'b1;
        pend_we = 1'b0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);   // Fill tied to every address bit
        end
        build_programs();
        tables_ready = 1;
        for (int t = 0; t < NT; t++) begin
            cur_test = t;
            t_err = errors;
            @(posedge clk);
            #2 reset = 1'b1;
            for (int i = 0; i < prog_len[t]; i++) begin
                for (int b = 0; b < 4; b++) begin
                    mem[20'(PROG_BASE + 32'(4*i + b))] = prog[t][i][31 - 8*b -: 8];
                end
            end
            repeat (10) @(posedge clk);
            #2 reset = 1'b0;
            seen_addr.delete();
            seen_data.delete();
            check_flag("hlt", 1'b0, hlt);
            check_flag("mem_req.store_we", 1'b0, mem_req.store_we);
            while (!hlt) @(negedge clk);
            repeat (5) @(negedge clk);   // Any store after halt would show up here
            check_flag("hlt", 1'b1, hlt);
            n = seen_addr.size();
            if (n != exp_cnt[t]) begin
                errors++;
                $display("Test %0d saw %0d stores but expected %0d", t, n, exp_cnt[t]);
            end
            for (int k = 0; k < n && k < exp_cnt[t]; k++) begin
                check_addr("mem_req.store_addr", exp_addr[t][k], seen_addr[k]);
                check_word("mem_req.store_data", exp_data[t][k], seen_data[k]);
            end
            $display("Test %0d %s: %s", t, names[t], (errors == t_err) ? "ok" : "errors");
        end
        $display("%0d tests, %0d checks, %0d errors", NT, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/cycle_sequencer.sv ====
// Five-state instruction cycle with PC, instruction register and sticky halt
`default_nettype none

module cycle_sequencer #(
    parameter tinker_isa_pkg::addr_t RESET_PC = 32'h2000
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire tinker_isa_pkg::addr_t    next_pc,
    input  wire tinker_isa_pkg::instr_t   mem_instr,
    output tinker_core_pkg::state_e       state,
    output tinker_isa_pkg::addr_t         pc,
    output tinker_isa_pkg::decoded_t      instr,
    output logic                          hlt
);

    tinker_core_pkg::state_e state_nxt;
    logic                    is_halt;

    assign is_halt = (instr.opcode == tinker_isa_pkg::OP_HALT);

    always_comb begin
        case (state)
            tinker_core_pkg::FETCH:     state_nxt = tinker_core_pkg::DECODE;
            tinker_core_pkg::DECODE:    state_nxt = is_halt ? tinker_core_pkg::DECODE
                                                            : tinker_core_pkg::EXECUTE;
            tinker_core_pkg::EXECUTE:   state_nxt = tinker_core_pkg::MEMORY;
            tinker_core_pkg::MEMORY:    state_nxt = tinker_core_pkg::WRITEBACK;
            default:                    state_nxt = tinker_core_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= tinker_core_pkg::FETCH;
            pc    <= RESET_PC;
            hlt   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == tinker_core_pkg::WRITEBACK)
                pc <= next_pc;                      // Only once per instruction
            if (state == tinker_core_pkg::DECODE && is_halt)
                hlt <= 1'b1;                        // Held until reset
        end
    end

    // Instruction register, loaded from the fetch response
    always_ff @(posedge clk) begin
        if (state == tinker_core_pkg::FETCH)
            instr <= tinker_isa_pkg::decoded_t'(mem_instr);
    end

    // Branch targets come from the datapath and must stay word aligned
    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        (pc % tinker_isa_pkg::INSTR_BYTES) == '0);

endmodule

`default_nettype wire

// ==== design/exec_control.sv ====
// Datapath control: operand selection, result and branch capture, memory requests
`default_nettype none

module exec_control (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire tinker_core_pkg::state_e  state,
    input  wire tinker_isa_pkg::addr_t    pc,
    input  wire tinker_isa_pkg::decoded_t instr,
    input  wire tinker_isa_pkg::word_t    op_a,
    input  wire tinker_isa_pkg::word_t    op_b,
    input  wire tinker_isa_pkg::word_t    load_data,
    output tinker_isa_pkg::reg_idx_t      addr_a,
    output tinker_isa_pkg::reg_idx_t      addr_b,
    output tinker_core_pkg::reg_write_t   wr,
    output tinker_isa_pkg::addr_t         next_pc,
    output tinker_isa_pkg::addr_t         load_addr,
    output tinker_isa_pkg::addr_t         store_addr,
    output tinker_isa_pkg::word_t         store_data,
    output logic                          store_we
);

    tinker_isa_pkg::opcode_e opcode;
    tinker_isa_pkg::word_t   alu_result;
    tinker_isa_pkg::word_t   result_q;
    tinker_isa_pkg::addr_t   branch_target;
    tinker_isa_pkg::addr_t   pc_plus4;
    tinker_isa_pkg::addr_t   lit_offset;
    logic                    gt_q;
    logic                    load_en;
    logic                    writes_result;
    logic                    in_memory;

    assign opcode     = instr.opcode;
    assign pc_plus4   = pc + tinker_isa_pkg::INSTR_BYTES;
    assign lit_offset = tinker_isa_pkg::addr_t'(instr.lit);   // Zero-extended displacement
    assign in_memory  = (state == tinker_core_pkg::MEMORY);

    int_alu u_alu (
        .opcode (opcode),
        .op1    (op_a),
        .op2    (op_b),
        .lit    (instr.lit),
        .result (alu_result)
    );

    always_comb begin
        addr_a = instr.rs;
        addr_b = instr.rt;
        case (opcode)
            tinker_isa_pkg::OP_ADDI, tinker_isa_pkg::OP_SUBI, tinker_isa_pkg::OP_SHFTRI,
            tinker_isa_pkg::OP_SHFTLI, tinker_isa_pkg::OP_MOV_RL,
            tinker_isa_pkg::OP_BR, tinker_isa_pkg::OP_BRR_R:
                addr_a = instr.rd;
            tinker_isa_pkg::OP_BRNZ:
                addr_b = instr.rd;                  // Target, rs is the test value
            tinker_isa_pkg::OP_CALL: begin
                addr_a = instr.rd;
                addr_b = tinker_isa_pkg::STACK_REG;
            end
            tinker_isa_pkg::OP_RETURN:
                addr_a = tinker_isa_pkg::STACK_REG;
            tinker_isa_pkg::OP_BRGT: begin
                // rs and rt compared in EXECUTE, rd read as the target afterwards
                if (in_memory)
                    addr_b = instr.rd;
            end
            tinker_isa_pkg::OP_STORE: begin
                addr_a = instr.rd;                  // Base
                addr_b = instr.rs;                  // Value
            end
            default: ;
        endcase
    end

    always_comb begin
        branch_target = pc_plus4;
        case (opcode)
            tinker_isa_pkg::OP_BR:     branch_target = op_a[31:0];
            tinker_isa_pkg::OP_BRR_R:  branch_target = pc + op_a[31:0];
            tinker_isa_pkg::OP_BRR_L:  branch_target = pc + tinker_isa_pkg::addr_t'($signed(instr.lit));
            tinker_isa_pkg::OP_BRNZ:   if (op_a != '0) branch_target = op_b[31:0];
            tinker_isa_pkg::OP_CALL:   branch_target = op_a[31:0];
            tinker_isa_pkg::OP_RETURN: branch_target = load_data[31:0];   // Saved return PC
            tinker_isa_pkg::OP_BRGT:   if (gt_q) branch_target = op_b[31:0];
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            tinker_isa_pkg::OP_ADD, tinker_isa_pkg::OP_ADDI, tinker_isa_pkg::OP_SUB,
            tinker_isa_pkg::OP_SUBI, tinker_isa_pkg::OP_AND, tinker_isa_pkg::OP_OR,
            tinker_isa_pkg::OP_XOR, tinker_isa_pkg::OP_NOT, tinker_isa_pkg::OP_SHFTR,
            tinker_isa_pkg::OP_SHFTRI, tinker_isa_pkg::OP_SHFTL, tinker_isa_pkg::OP_SHFTLI,
            tinker_isa_pkg::OP_MOV_RR, tinker_isa_pkg::OP_MOV_RL, tinker_isa_pkg::OP_LOAD:
                writes_result = 1'b1;
            default:
                writes_result = 1'b0;
        endcase
    end

    // Taken flag for brgt, signed compare of rs and rt
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            gt_q <= 1'b0;
        else if (state == tinker_core_pkg::EXECUTE)
            gt_q <= $signed(op_a) > $signed(op_b);
    end

    always_ff @(posedge clk) begin
        if (state == tinker_core_pkg::EXECUTE)
            result_q <= alu_result;
        if (in_memory) begin
            if (opcode == tinker_isa_pkg::OP_LOAD)
                result_q <= load_data;
            next_pc <= branch_target;
        end
    end

    assign wr = '{we: (state == tinker_core_pkg::WRITEBACK) && writes_result,
                  addr: instr.rd, data: result_q};

    assign load_en    = in_memory && (opcode == tinker_isa_pkg::OP_LOAD ||
                                      opcode == tinker_isa_pkg::OP_RETURN);
    assign load_addr  = (opcode == tinker_isa_pkg::OP_RETURN)
                      ? op_a[31:0] - tinker_isa_pkg::WORD_BYTES
                      : op_a[31:0] + lit_offset;
    assign store_we   = in_memory && (opcode == tinker_isa_pkg::OP_CALL ||
                                      opcode == tinker_isa_pkg::OP_STORE);
    assign store_addr = (opcode == tinker_isa_pkg::OP_CALL)
                      ? op_b[31:0] - tinker_isa_pkg::WORD_BYTES   // Push below r31
                      : op_a[31:0] + lit_offset;
    assign store_data = (opcode == tinker_isa_pkg::OP_CALL)
                      ? tinker_isa_pkg::word_t'(pc_plus4) : op_b;

    // Memory access lasts one cycle, the sequencer must move on from MEMORY
    single_mem_cycle: assert property (@(posedge clk) disable iff (reset)
        (store_we || load_en) |=> !(store_we || load_en));

endmodule

`default_nettype wire

// ==== design/int_alu.sv ====
// Combinational integer ALU, operation chosen directly by the opcode
`default_nettype none

module int_alu (
    input  wire tinker_isa_pkg::opcode_e  opcode,
    input  wire tinker_isa_pkg::word_t    op1,
    input  wire tinker_isa_pkg::word_t    op2,
    input  wire tinker_isa_pkg::literal_t lit,
    output tinker_isa_pkg::word_t         result
);

    tinker_isa_pkg::word_t lit_sx;
    tinker_isa_pkg::word_t lit_zx;

    assign lit_sx = tinker_isa_pkg::word_t'($signed(lit));
    assign lit_zx = tinker_isa_pkg::word_t'(lit);

    always_comb begin
        case (opcode)
            tinker_isa_pkg::OP_ADD:    result = op1 + op2;
            tinker_isa_pkg::OP_ADDI:   result = op1 + lit_sx;   // L is signed here
            tinker_isa_pkg::OP_SUB:    result = op1 - op2;
            tinker_isa_pkg::OP_SUBI:   result = op1 - lit_zx;   // but unsigned here
            tinker_isa_pkg::OP_AND:    result = op1 & op2;
            tinker_isa_pkg::OP_OR:     result = op1 | op2;
            tinker_isa_pkg::OP_XOR:    result = op1 ^ op2;
            tinker_isa_pkg::OP_NOT:    result = ~op1;
            tinker_isa_pkg::OP_SHFTR:  result = op1 >> op2;
            tinker_isa_pkg::OP_SHFTRI: result = op1 >> lit;
            tinker_isa_pkg::OP_SHFTL:  result = op1 << op2;
            tinker_isa_pkg::OP_SHFTLI: result = op1 << lit;
            tinker_isa_pkg::OP_MOV_RR: result = op1;
            tinker_isa_pkg::OP_MOV_RL: begin
                // Upper bits of rd survive
                result = {op1[tinker_isa_pkg::WORD_W-1:tinker_isa_pkg::LIT_W], lit};
            end
            default:                   result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// General register file, 32 x 64 bits, two combinational reads and one write
`default_nettype none

module reg_file #(
    parameter tinker_isa_pkg::word_t STACK_TOP = 64'h80000
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire tinker_isa_pkg::reg_idx_t   addr_a,
    input  wire tinker_isa_pkg::reg_idx_t   addr_b,
    input  wire tinker_core_pkg::reg_write_t wr,
    output tinker_isa_pkg::word_t           op_a,
    output tinker_isa_pkg::word_t           op_b
);

    localparam int NUM_REGS = 2 ** tinker_isa_pkg::REG_IDX_W;

    tinker_isa_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                // Stack pointer starts at the top of the stack
                regs[i] <= (i == tinker_isa_pkg::STACK_REG) ? STACK_TOP : '0;
            end
        end else if (wr.we) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign op_a = regs[addr_a];
    assign op_b = regs[addr_b];

    // Result register upstream must hold a defined value by writeback
    wr_data_known: assert property (@(posedge clk) disable iff (reset)
        wr.we |-> !$isunknown(wr.data));

endmodule

`default_nettype wire

// ==== design/tinker_core.sv ====
// Tinker core top level, memory sits outside behind the request/response ports
`default_nettype none

module tinker_core #(
    parameter tinker_isa_pkg::addr_t RESET_PC  = 32'h2000,
    parameter tinker_isa_pkg::word_t STACK_TOP = 64'h80000
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    output tinker_core_pkg::mem_req_t      mem_req,
    input  wire tinker_core_pkg::mem_rsp_t mem_rsp,
    output logic                           hlt
);

    tinker_core_pkg::state_e     state;
    tinker_isa_pkg::addr_t       pc;
    tinker_isa_pkg::addr_t       next_pc;
    tinker_isa_pkg::decoded_t    instr;
    tinker_isa_pkg::reg_idx_t    addr_a;
    tinker_isa_pkg::reg_idx_t    addr_b;
    tinker_isa_pkg::word_t       op_a;
    tinker_isa_pkg::word_t       op_b;
    tinker_core_pkg::reg_write_t wr;
    tinker_isa_pkg::addr_t       load_addr;
    tinker_isa_pkg::addr_t       store_addr;
    tinker_isa_pkg::word_t       store_data;
    logic                        store_we;

    cycle_sequencer #(.RESET_PC(RESET_PC)) u_seq (
        .clk       (clk),
        .reset     (reset),
        .next_pc   (next_pc),
        .mem_instr (mem_rsp.instruction),
        .state     (state),
        .pc        (pc),
        .instr     (instr),
        .hlt       (hlt)
    );

    reg_file #(.STACK_TOP(STACK_TOP)) u_regs (
        .clk    (clk),
        .reset  (reset),
        .addr_a (addr_a),
        .addr_b (addr_b),
        .wr     (wr),
        .op_a   (op_a),
        .op_b   (op_b)
    );

    exec_control u_exec (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .pc         (pc),
        .instr      (instr),
        .op_a       (op_a),
        .op_b       (op_b),
        .load_data  (mem_rsp.load_data),
        .addr_a     (addr_a),
        .addr_b     (addr_b),
        .wr         (wr),
        .next_pc    (next_pc),
        .load_addr  (load_addr),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_we   (store_we)
    );

    // Fetch address is the PC itself
    assign mem_req = '{fetch_addr: pc, load_addr: load_addr, store_we: store_we,
                       store_addr: store_addr, store_data: store_data};

endmodule

`default_nettype wire

// ==== design/tinker_core_pkg.sv ====
// Core-level types shared by the sequencer, datapath and top level: states and ports
`default_nettype none

package tinker_core_pkg;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } state_e;

    // Core to external memory, all levels except the store strobe
    typedef struct packed {
        tinker_isa_pkg::addr_t fetch_addr;
        tinker_isa_pkg::addr_t load_addr;
        logic                  store_we;
        tinker_isa_pkg::addr_t store_addr;
        tinker_isa_pkg::word_t store_data;
    } mem_req_t;

    // Returned combinationally in the same cycle
    typedef struct packed {
        tinker_isa_pkg::instr_t instruction;
        tinker_isa_pkg::word_t  load_data;
    } mem_rsp_t;

    typedef struct packed {
        logic                     we;
        tinker_isa_pkg::reg_idx_t addr;
        tinker_isa_pkg::word_t    data;
    } reg_write_t;

endpackage

`default_nettype wire

// ==== design/tinker_isa_pkg.sv ====
// Tinker instruction set types, opcodes and field layout, referenced by scoped name
`default_nettype none

package tinker_isa_pkg;

    localparam int WORD_W    = 64;
    localparam int ADDR_W    = 32;
    localparam int INSTR_W   = 32;
    localparam int OPCODE_W  = 5;
    localparam int REG_IDX_W = 5;
    localparam int LIT_W     = 12;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [LIT_W-1:0]     literal_t;

    // Integer subset only, encodings as in the full ISA
    typedef enum logic [OPCODE_W-1:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,
        OP_BRR_R  = 5'h09,   // brr rd
        OP_BRR_L  = 5'h0a,   // brr L
        OP_BRNZ   = 5'h0b,
        OP_CALL   = 5'h0c,
        OP_RETURN = 5'h0d,
        OP_BRGT   = 5'h0e,
        OP_HALT   = 5'h0f,
        OP_LOAD   = 5'h10,   // mov rd, (rs)(L)
        OP_MOV_RR = 5'h11,   // mov rd, rs
        OP_MOV_RL = 5'h12,   // mov rd, L
        OP_STORE  = 5'h13,   // mov (rd)(L), rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b
    } opcode_e;

    // Same bit order as the raw instruction, opcode in 31:27
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        literal_t lit;
    } decoded_t;

    localparam addr_t    INSTR_BYTES = 32'd4;
    localparam addr_t    WORD_BYTES  = 32'd8;   // Stack slot size
    localparam reg_idx_t STACK_REG   = 5'd31;

endpackage

`default_nettype wire

// ==== tinker_core.f ====
design/tinker_isa_pkg.sv
design/tinker_core_pkg.sv
design/cycle_sequencer.sv
design/reg_file.sv
design/int_alu.sv
design/exec_control.sv
design/tinker_core.sv
+incdir+bench
bench/tb_tinker_core.sv
